//--- build.f
common/mem_pipe_pkg.sv
memory_pipeline/mem_inst_decode.sv
memory_pipeline/mem_addr_stage.sv
memory_pipeline/dcache_data_stage.sv
memory_pipeline/dcache_data_array.sv
memory_pipeline/load_align_stage.sv
source/memory_pipeline_top.sv
verif/tb_clock_gen.sv
verif/memory_pipeline_tb.sv

//--- common/mem_pipe_pkg.sv
package mem_pipe_pkg;

	// Vector and line geometry
	localparam int vector_lanes = 16;
	localparam int cache_line_bytes = 64;
	localparam int cache_line_offset_bits = 6;
	localparam int cache_line_bits = 512;
	localparam int array_lines = 16;
	localparam int array_index_bits = 4;
	localparam int thread_count = 4;

	// Upper address half that selects the I/O space
	localparam logic [15:0] io_prefix = 16'hffff;

	// Instruction word fields
	localparam int inst_load_bit = 29;
	localparam int inst_op_msb = 28;
	localparam int inst_op_lsb = 25;
	localparam int inst_offset_msb = 14;

	typedef logic [31:0] scalar_t;
	typedef scalar_t [vector_lanes-1:0] vector_t;
	typedef logic [vector_lanes-1:0] lane_mask_t;
	typedef logic [$clog2(thread_count)-1:0] thread_idx_t;
	typedef logic [$clog2(vector_lanes)-1:0] subcycle_t;

	// Gaps are the unused sync, control and strided encodings
	typedef enum logic [3:0] {
		MEM_B = 4'd0,
		MEM_BX = 4'd1,
		MEM_S = 4'd2,
		MEM_SX = 4'd3,
		MEM_L = 4'd4,
		MEM_BLOCK = 4'd7,
		MEM_BLOCK_M = 4'd8,
		MEM_BLOCK_IM = 4'd9,
		MEM_SCGATH = 4'd13,
		MEM_SCGATH_M = 4'd14,
		MEM_SCGATH_IM = 4'd15
	} mem_op_e;

	typedef struct packed {
		scalar_t instruction;
		thread_idx_t thread;
		scalar_t base;
		lane_mask_t mask;
		vector_t store_value;
		vector_t pointers;
	} mem_issue_t;

	typedef struct packed {
		mem_op_e op;
		logic is_load;
		scalar_t offset;
		lane_mask_t mask;
		thread_idx_t thread;
		scalar_t base;
		vector_t store_value;
		vector_t pointers;
	} decoded_mem_t;

	typedef struct packed {
		mem_op_e op;
		logic is_load;
		lane_mask_t mask;
		thread_idx_t thread;
		scalar_t request_addr;
		subcycle_t subcycle;
		logic last_subcycle;
		vector_t store_value;
	} mem_request_t;

	typedef struct packed {
		mem_op_e op;
		logic is_load;
		lane_mask_t mask;
		thread_idx_t thread;
		scalar_t request_addr;
		subcycle_t subcycle;
		logic last_subcycle;
		logic is_io;
	} data_result_t;

	typedef struct packed {
		thread_idx_t thread;
		vector_t data;
		lane_mask_t mask;
	} load_result_t;

	// Reverses byte order between a register word and its line image
	function automatic scalar_t swap_bytes(input scalar_t value);
		return {value[7:0], value[15:8], value[23:16], value[31:24]};
	endfunction

endpackage

//--- memory_pipeline/dcache_data_array.sv
`timescale 1ns/100ps

module dcache_data_array
	import mem_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic read_en,
	input logic write_en,
	input logic [array_index_bits-1:0] line_index,
	input logic [cache_line_bits-1:0] write_data,
	input logic [cache_line_bytes-1:0] write_mask,
	output logic [cache_line_bits-1:0] read_line
);

	logic [cache_line_bits-1:0] lines [array_lines];

	// Byte enables, byte b of the line at bits 8b
	always_ff @(posedge clk)
	begin
		if (write_en)
		begin
			for (int b = 0; b < cache_line_bytes; b++)
			begin
				if (write_mask[b])
					lines[line_index][8 * b +: 8] <= write_data[8 * b +: 8];
			end
		end
	end

	// Same-cycle write to the read line is not forwarded
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			read_line <= '0;
		else if (read_en)
			read_line <= lines[line_index];
	end

endmodule

//--- memory_pipeline/dcache_data_stage.sv
`timescale 1ns/100ps

module dcache_data_stage
	import mem_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	input mem_request_t req,
	input logic rollback_en,
	input thread_idx_t rollback_thread,
	output logic read_en,
	output logic write_en,
	output logic [array_index_bits-1:0] line_index,
	output logic [cache_line_bits-1:0] write_data,
	output logic [cache_line_bytes-1:0] write_mask,
	output logic dd_valid,
	output data_result_t dd,
	output logic io_write_en,
	output logic [7:0] io_write_data
);

	logic is_io;
	logic squash;
	logic access_ok;
	logic [cache_line_offset_bits-3:0] word_idx;
	lane_mask_t word_write_mask;
	logic [3:0] byte_write_mask;
	scalar_t store_word;
	scalar_t lane_store_value;
	logic [cache_line_bits-1:0] block_image;

	assign is_io = req.request_addr[31:16] == io_prefix;
	assign squash = rollback_en && rollback_thread == req.thread;
	assign access_ok = req_valid && !squash && !is_io;

	assign word_idx = req.request_addr[cache_line_offset_bits-1:2];
	assign line_index = req.request_addr[cache_line_offset_bits +: array_index_bits];
	assign store_word = req.store_value[0];
	assign lane_store_value = req.store_value[req.subcycle];

	assign read_en = access_ok && req.is_load;
	assign write_en = access_ok && !req.is_load && |write_mask;

	// Lanes touched in the line
	always_comb
	begin
		case (req.op)
			MEM_BLOCK, MEM_BLOCK_M, MEM_BLOCK_IM:
				word_write_mask = req.mask;
			MEM_SCGATH, MEM_SCGATH_M, MEM_SCGATH_IM:
				word_write_mask = req.mask[req.subcycle] ? lane_mask_t'(1) << word_idx : '0;
			default:
				word_write_mask = lane_mask_t'(1) << word_idx;
		endcase
	end

	// Block store line image, lane k into word k
	always_comb
	begin
		for (int k = 0; k < vector_lanes; k++)
			block_image[32 * k +: 32] = swap_bytes(req.store_value[k]);
	end

	// Bytes within the word, and the replicated store data
	always_comb
	begin
		case (req.op)
			MEM_B, MEM_BX:
			begin
				case (req.request_addr[1:0])
					2'b00:
					begin
						byte_write_mask = 4'b0001;
						write_data = {vector_lanes{24'd0, store_word[7:0]}};
					end
					2'b01:
					begin
						byte_write_mask = 4'b0010;
						write_data = {vector_lanes{16'd0, store_word[7:0], 8'd0}};
					end
					2'b10:
					begin
						byte_write_mask = 4'b0100;
						write_data = {vector_lanes{8'd0, store_word[7:0], 16'd0}};
					end
					default:
					begin
						byte_write_mask = 4'b1000;
						write_data = {vector_lanes{store_word[7:0], 24'd0}};
					end
				endcase
			end

			MEM_S, MEM_SX:
			begin
				if (!req.request_addr[1])
				begin
					byte_write_mask = 4'b0011;
					write_data = {vector_lanes{16'd0, store_word[7:0], store_word[15:8]}};
				end
				else
				begin
					byte_write_mask = 4'b1100;
					write_data = {vector_lanes{store_word[7:0], store_word[15:8], 16'd0}};
				end
			end

			MEM_L:
			begin
				byte_write_mask = 4'b1111;
				write_data = {vector_lanes{swap_bytes(store_word)}};
			end

			MEM_SCGATH, MEM_SCGATH_M, MEM_SCGATH_IM:
			begin
				byte_write_mask = 4'b1111;
				write_data = {vector_lanes{swap_bytes(lane_store_value)}};
			end

			default:
			begin
				byte_write_mask = 4'b1111;
				write_data = block_image;
			end
		endcase
	end

	// Either a few bytes of one word, or whole words of the line
	always_comb
	begin
		for (int b = 0; b < cache_line_bytes; b++)
			write_mask[b] = word_write_mask[b / 4] & byte_write_mask[b % 4];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			dd_valid <= 1'b0;
			io_write_en <= 1'b0;
		end
		else
		begin
			dd_valid <= req_valid && !squash;
			io_write_en <= req_valid && !squash && is_io && !req.is_load;
		end
	end

	always_ff @(posedge clk)
	begin
		dd.op <= req.op;
		dd.is_load <= req.is_load;
		dd.mask <= req.mask;
		dd.thread <= req.thread;
		dd.request_addr <= req.request_addr;
		dd.subcycle <= req.subcycle;
		dd.last_subcycle <= req.last_subcycle;
		dd.is_io <= is_io;
		io_write_data <= store_word[7:0];
	end

endmodule

//--- memory_pipeline/load_align_stage.sv
`timescale 1ns/100ps

module load_align_stage
	import mem_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic dd_valid,
	input data_result_t dd,
	input logic [cache_line_bits-1:0] read_line,
	output logic result_valid,
	output load_result_t result
);

	logic [cache_line_offset_bits-3:0] word_idx;
	scalar_t raw_word;
	scalar_t be_word;
	logic [7:0] byte_val;
	logic [15:0] half_val;
	scalar_t ext_value;
	logic is_gather;
	logic is_block;
	logic load_ok;
	logic in_sequence;
	logic result_ready;
	logic gather_ok;
	subcycle_t next_beat;
	vector_t gather_data;
	vector_t gathered;
	vector_t block_data;
	vector_t scalar_data;

	assign word_idx = dd.request_addr[cache_line_offset_bits-1:2];
	assign raw_word = read_line[32 * word_idx +: 32];
	assign be_word = swap_bytes(raw_word);
	assign byte_val = raw_word[8 * dd.request_addr[1:0] +: 8];
	assign half_val = dd.request_addr[1] ? be_word[15:0] : be_word[31:16];

	assign is_gather = dd.op inside {MEM_SCGATH, MEM_SCGATH_M, MEM_SCGATH_IM};
	assign is_block = dd.op inside {MEM_BLOCK, MEM_BLOCK_M, MEM_BLOCK_IM};
	assign load_ok = dd_valid && dd.is_load && !dd.is_io;

	// A squashed beat breaks the run and the gather is dropped
	assign in_sequence = dd.subcycle == '0 || (gather_ok && dd.subcycle == next_beat);
	assign result_ready = load_ok && dd.last_subcycle && (!is_gather || in_sequence);

	always_comb
	begin
		case (dd.op)
			MEM_B:
				ext_value = {24'd0, byte_val};
			MEM_BX:
				ext_value = {{24{byte_val[7]}}, byte_val};
			MEM_S:
				ext_value = {16'd0, half_val};
			MEM_SX:
				ext_value = {{16{half_val[15]}}, half_val};
			default:
				ext_value = be_word;
		endcase
	end

	always_comb
	begin
		scalar_data = '0;
		scalar_data[0] = ext_value;
		gathered = gather_data;
		gathered[dd.subcycle] = dd.mask[dd.subcycle] ? be_word : '0;
		for (int k = 0; k < vector_lanes; k++)
			block_data[k] = dd.mask[k] ? swap_bytes(read_line[32 * k +: 32]) : '0;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			result_valid <= 1'b0;
			gather_ok <= 1'b0;
			next_beat <= '0;
		end
		else
		begin
			result_valid <= result_ready;
			if (load_ok && is_gather)
			begin
				gather_ok <= in_sequence;
				next_beat <= dd.subcycle + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (load_ok && is_gather)
			gather_data <= gathered;

		if (result_ready)
		begin
			result.thread <= dd.thread;
			result.mask <= dd.mask;
			if (is_gather)
				result.data <= gathered;
			else if (is_block)
				result.data <= block_data;
			else
				result.data <= scalar_data;
		end
	end

endmodule

//--- memory_pipeline/mem_addr_stage.sv
`timescale 1ns/100ps

module mem_addr_stage
	import mem_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic dec_valid,
	input decoded_mem_t dec,
	output logic addr_busy,
	output logic req_valid,
	output mem_request_t req
);

	typedef enum logic {
		state_idle,
		state_walk
	} addr_state_e;

	addr_state_e state;
	subcycle_t beat;
	decoded_mem_t walk;
	decoded_mem_t src;
	subcycle_t src_beat;
	logic src_scgath;
	scalar_t sum;
	scalar_t beat_addr;

	assign addr_busy = state == state_walk;

	// During a walk the latched copy drives the beats
	assign src = addr_busy ? walk : dec;
	assign src_beat = addr_busy ? beat : '0;
	assign src_scgath = src.op inside {MEM_SCGATH, MEM_SCGATH_M, MEM_SCGATH_IM};
	assign sum = src.base + src.offset;

	always_comb
	begin
		case (src.op)
			MEM_BLOCK, MEM_BLOCK_M, MEM_BLOCK_IM:
				beat_addr = {sum[31:cache_line_offset_bits], {cache_line_offset_bits{1'b0}}};
			MEM_SCGATH, MEM_SCGATH_M, MEM_SCGATH_IM:
				beat_addr = src.pointers[src_beat];
			default:
				beat_addr = sum;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= state_idle;
			beat <= '0;
			req_valid <= 1'b0;
		end
		else if (addr_busy)
		begin
			req_valid <= 1'b1;
			beat <= beat + 1'b1;
			if (beat == '1)
				state <= state_idle;
		end
		else
		begin
			req_valid <= dec_valid;
			if (dec_valid && src_scgath)
			begin
				state <= state_walk;
				beat <= subcycle_t'(1);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!addr_busy)
			walk <= dec;

		req.op <= src.op;
		req.is_load <= src.is_load;
		req.mask <= src.mask;
		req.thread <= src.thread;
		req.request_addr <= beat_addr;
		req.subcycle <= src_beat;
		req.last_subcycle <= !src_scgath || src_beat == '1;
		req.store_value <= src.store_value;
	end

endmodule

//--- memory_pipeline/mem_inst_decode.sv
`timescale 1ns/100ps

module mem_inst_decode
	import mem_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input mem_issue_t issue,
	input logic addr_busy,
	output logic issue_ready,
	output logic dec_valid,
	output decoded_mem_t dec
);

	mem_op_e op;
	lane_mask_t eff_mask;

	// New work is taken only while the address stage is free
	assign issue_ready = !addr_busy;
	assign op = mem_op_e'(issue.instruction[inst_op_msb:inst_op_lsb]);

	// Lane mask from the opcode variant
	always_comb
	begin
		case (op)
			MEM_BLOCK, MEM_SCGATH:
				eff_mask = '1;
			MEM_BLOCK_M, MEM_SCGATH_M:
				eff_mask = issue.mask;
			MEM_BLOCK_IM, MEM_SCGATH_IM:
				eff_mask = ~issue.mask;
			default:
				eff_mask = lane_mask_t'(1);
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			dec_valid <= 1'b0;
		else if (issue_ready)
			dec_valid <= issue_valid;
	end

	// Held while the address stage walks a gather or scatter
	always_ff @(posedge clk)
	begin
		if (issue_ready && issue_valid)
		begin
			dec.op <= op;
			dec.is_load <= issue.instruction[inst_load_bit];
			dec.offset <= {{(31 - inst_offset_msb){issue.instruction[inst_offset_msb]}},
				issue.instruction[inst_offset_msb:0]};
			dec.mask <= eff_mask;
			dec.thread <= issue.thread;
			dec.base <= issue.base;
			dec.store_value <= issue.store_value;
			dec.pointers <= issue.pointers;
		end
	end

endmodule

//--- source/memory_pipeline_top.sv
`timescale 1ns/100ps

module memory_pipeline_top
	import mem_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input mem_issue_t issue,
	input logic rollback_en,
	input thread_idx_t rollback_thread,
	output logic issue_ready,
	output logic result_valid,
	output load_result_t result,
	output logic io_write_en,
	output logic [7:0] io_write_data
);

	logic dec_valid;
	decoded_mem_t dec;
	logic addr_busy;
	logic req_valid;
	mem_request_t req;
	logic read_en;
	logic write_en;
	logic [array_index_bits-1:0] line_index;
	logic [cache_line_bits-1:0] write_data;
	logic [cache_line_bytes-1:0] write_mask;
	logic [cache_line_bits-1:0] read_line;
	logic dd_valid;
	data_result_t dd;

	mem_inst_decode decode0(
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue(issue),
		.addr_busy(addr_busy),
		.issue_ready(issue_ready),
		.dec_valid(dec_valid),
		.dec(dec)
	);

	mem_addr_stage addr0(
		.clk(clk),
		.reset(reset),
		.dec_valid(dec_valid),
		.dec(dec),
		.addr_busy(addr_busy),
		.req_valid(req_valid),
		.req(req)
	);

	dcache_data_stage data0(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.read_en(read_en),
		.write_en(write_en),
		.line_index(line_index),
		.write_data(write_data),
		.write_mask(write_mask),
		.dd_valid(dd_valid),
		.dd(dd),
		.io_write_en(io_write_en),
		.io_write_data(io_write_data)
	);

	dcache_data_array array0(
		.clk(clk),
		.reset(reset),
		.read_en(read_en),
		.write_en(write_en),
		.line_index(line_index),
		.write_data(write_data),
		.write_mask(write_mask),
		.read_line(read_line)
	);

	load_align_stage align0(
		.clk(clk),
		.reset(reset),
		.dd_valid(dd_valid),
		.dd(dd),
		.read_line(read_line),
		.result_valid(result_valid),
		.result(result)
	);

endmodule

//--- verif/memory_pipeline_tb.sv
`timescale 1ns/100ps

module memory_pipeline_tb
	import mem_pipe_pkg::*;
();

	// Sum of the test lengths is about 700 cycles
	localparam int cycle_limit = 2000;

	logic clk;
	logic reset;
	logic issue_valid;
	mem_issue_t issue;
	logic rollback_en;
	thread_idx_t rollback_thread;
	logic issue_ready;
	logic result_valid;
	load_result_t result;
	logic io_write_en;
	logic [7:0] io_write_data;

	// Byte-addressed model of the array, address modulo 1 KiB
	logic [7:0] shadow [1024];
	int cycle_count = 0;

	tb_clock_gen clock0(
		.clk(clk),
		.reset(reset)
	);

	memory_pipeline_top dut0(
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue(issue),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.issue_ready(issue_ready),
		.result_valid(result_valid),
		.result(result),
		.io_write_en(io_write_en),
		.io_write_data(io_write_data)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "Run stopped");
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
			stop_run("Timeout, the run went past its cycle limit");
	end

	task automatic compare_result(input string name, input load_result_t expected,
		input load_result_t actual);
		if (actual !== expected)
			stop_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic compare_io_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
			stop_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
	endtask

	// Strobe timing in cycles after the issue edge
	task automatic compare_valid(input string name, input int expected, input int actual);
		if (actual != expected)
			stop_run($sformatf("Error: %s expected %0d actual %0d", name, expected, actual));
	endtask

	function automatic scalar_t make_inst(input logic is_load, input mem_op_e op, input int offset);
		logic [14:0] off_field;
		off_field = offset[14:0];
		return {2'b00, is_load, op, 10'd0, off_field};
	endfunction

	function automatic mem_issue_t make_issue(input scalar_t inst, input thread_idx_t thread,
		input scalar_t base, input lane_mask_t mask, input vector_t store_value,
		input vector_t pointers);
		mem_issue_t v;
		v.instruction = inst;
		v.thread = thread;
		v.base = base;
		v.mask = mask;
		v.store_value = store_value;
		v.pointers = pointers;
		return v;
	endfunction

	function automatic vector_t random_vector();
		vector_t v;
		for (int k = 0; k < vector_lanes; k++)
			v[k] = $urandom;
		return v;
	endfunction

	// Big endian, offset 0 is the most significant byte
	function automatic scalar_t shadow_word(input scalar_t addr);
		logic [9:0] a;
		a = {addr[9:2], 2'b00};
		return {shadow[a], shadow[a + 10'd1], shadow[a + 10'd2], shadow[a + 10'd3]};
	endfunction

	task automatic shadow_word_write(input scalar_t addr, input scalar_t value);
		logic [9:0] a;
		a = {addr[9:2], 2'b00};
		shadow[a] = value[31:24];
		shadow[a + 10'd1] = value[23:16];
		shadow[a + 10'd2] = value[15:8];
		shadow[a + 10'd3] = value[7:0];
	endtask

	task automatic shadow_store(input mem_op_e op, input scalar_t addr, input scalar_t value);
		logic [9:0] a;
		a = addr[9:0];
		case (op)
			MEM_B, MEM_BX:
				shadow[a] = value[7:0];
			MEM_S, MEM_SX:
			begin
				shadow[{a[9:1], 1'b0}] = value[15:8];
				shadow[{a[9:1], 1'b1}] = value[7:0];
			end
			default:
				shadow_word_write(addr, value);
		endcase
	endtask

	function automatic scalar_t scalar_expect(input mem_op_e op, input scalar_t addr);
		logic [9:0] a;
		logic [7:0] b;
		logic [15:0] h;
		a = addr[9:0];
		b = shadow[a];
		h = {shadow[{a[9:1], 1'b0}], shadow[{a[9:1], 1'b1}]};
		case (op)
			MEM_B: return {24'd0, b};
			MEM_BX: return {{24{b[7]}}, b};
			MEM_S: return {16'd0, h};
			MEM_SX: return {{16{h[15]}}, h};
			default: return shadow_word(addr);
		endcase
	endfunction

	task automatic issue_op(input mem_issue_t v);
		@(posedge clk);
		issue_valid <= 1'b1;
		issue <= v;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		issue_valid <= 1'b0;
		rollback_en <= 1'b0;
	endtask

	task automatic wait_result(input string name, input int latency);
		int n;
		n = 0;
		do
		begin
			next_cycle();
			n++;
			@(negedge clk);
			if (n > 40)
				stop_run($sformatf("No load result arrived for %s", name));
		end
		while (!result_valid);
		compare_valid(name, latency, n);
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles)
		begin
			next_cycle();
			@(negedge clk);
			if (result_valid)
				stop_run("A load result appeared where none was expected");
			if (io_write_en)
				stop_run("An io_write_en pulse appeared where none was expected");
		end
	endtask

	// Base is 32 above the target so the negative offset is used
	task automatic scalar_store(input mem_op_e op, input scalar_t addr, input scalar_t value,
		input thread_idx_t thread);
		vector_t data;
		data = '0;
		data[0] = value;
		issue_op(make_issue(make_inst(1'b0, op, -32), thread, addr + 32, '0, data, '0));
		shadow_store(op, addr, value);
		expect_quiet(5);
	endtask

	task automatic scalar_load(input string name, input mem_op_e op, input scalar_t addr,
		input thread_idx_t thread);
		load_result_t expected;
		expected = '0;
		expected.thread = thread;
		expected.mask = lane_mask_t'(1);
		expected.data[0] = scalar_expect(op, addr);
		issue_op(make_issue(make_inst(1'b1, op, -32), thread, addr + 32, '0, '0, '0));
		wait_result(name, 4);
		compare_result(name, expected, result);
	endtask

	// Address lands inside the line, the stage clears the line offset
	task automatic block_store(input mem_op_e op, input scalar_t line_addr, input lane_mask_t mask,
		input vector_t values, input thread_idx_t thread);
		lane_mask_t lanes;
		case (op)
			MEM_BLOCK_M: lanes = mask;
			MEM_BLOCK_IM: lanes = ~mask;
			default: lanes = '1;
		endcase
		issue_op(make_issue(make_inst(1'b0, op, 8), thread, line_addr + 20, mask, values, '0));
		for (int k = 0; k < vector_lanes; k++)
		begin
			if (lanes[k])
				shadow_word_write(line_addr + scalar_t'(4 * k), values[k]);
		end
		expect_quiet(5);
	endtask

	task automatic block_load(input string name, input scalar_t line_addr, input thread_idx_t thread);
		load_result_t expected;
		expected.thread = thread;
		expected.mask = '1;
		for (int k = 0; k < vector_lanes; k++)
			expected.data[k] = shadow_word(line_addr + scalar_t'(4 * k));
		issue_op(make_issue(make_inst(1'b1, MEM_BLOCK, 8), thread, line_addr + 20, '0, '0, '0));
		wait_result(name, 4);
		compare_result(name, expected, result);
	endtask

	task automatic store_with_rollback(input scalar_t addr, input scalar_t value,
		input thread_idx_t thread, input thread_idx_t rb_thread);
		vector_t data;
		data = '0;
		data[0] = value;
		issue_op(make_issue(make_inst(1'b0, MEM_L, -32), thread, addr + 32, '0, data, '0));
		next_cycle();
		// Store is in the data stage during the next cycle
		@(posedge clk);
		rollback_en <= 1'b1;
		rollback_thread <= rb_thread;
		expect_quiet(5);
		if (rb_thread != thread)
			shadow_word_write(addr, value);
	endtask

	task automatic init_array_test();
		for (int line = 0; line < array_lines; line++)
			block_store(MEM_BLOCK, scalar_t'(line * cache_line_bytes), '0, random_vector(), 0);
	endtask

	task automatic scalar_store_load_test();
		scalar_t addr;
		thread_idx_t thread;
		for (int i = 0; i < 3; i++)
		begin
			addr = $urandom & 32'h0000_03fc;
			thread = thread_idx_t'(i);
			for (int off = 0; off < 4; off++)
			begin
				scalar_store(MEM_B, addr + off, $urandom, thread);
				scalar_load("byte store then word load", MEM_L, addr, thread);
			end
			for (int off = 0; off < 4; off += 2)
			begin
				scalar_store(MEM_S, addr + off, $urandom, thread);
				scalar_load("halfword store then word load", MEM_L, addr, thread);
			end
			scalar_store(MEM_L, addr, $urandom, thread);
			scalar_load("word store then word load", MEM_L, addr, thread);
		end
	endtask

	task automatic extend_test();
		scalar_t addr;
		scalar_t value;
		for (int i = 0; i < 2; i++)
		begin
			addr = $urandom & 32'h0000_03fc;
			// One word with all byte signs set, one with none
			value = (i == 0) ? ($urandom | 32'h8080_8080) : ($urandom & 32'h7f7f_7f7f);
			scalar_store(MEM_L, addr, value, 2);
			for (int off = 0; off < 4; off++)
			begin
				scalar_load("zero-extended byte load", MEM_B, addr + off, 2);
				scalar_load("sign-extended byte load", MEM_BX, addr + off, 2);
			end
			for (int off = 0; off < 4; off += 2)
			begin
				scalar_load("zero-extended halfword load", MEM_S, addr + off, 2);
				scalar_load("sign-extended halfword load", MEM_SX, addr + off, 2);
			end
		end
	endtask

	task automatic block_mask_test();
		scalar_t line_addr;
		line_addr = $urandom & 32'h0000_03c0;
		block_store(MEM_BLOCK_M, line_addr, $urandom, random_vector(), 1);
		block_load("block load after masked block store", line_addr, 1);
		block_store(MEM_BLOCK_IM, line_addr, $urandom, random_vector(), 1);
		block_load("block load after inverse-masked block store", line_addr, 1);
	endtask

	task automatic scatter_gather_test();
		vector_t pointers;
		vector_t values;
		lane_mask_t mask;
		load_result_t expected;
		values = random_vector();
		for (int k = 0; k < vector_lanes; k++)
			pointers[k] = $urandom & 32'h0000_fffc;
		issue_op(make_issue(make_inst(1'b0, MEM_SCGATH, 0), 3, '0, '0, values, pointers));
		// Beats go out in lane order, so a repeated pointer keeps the last lane
		for (int k = 0; k < vector_lanes; k++)
			shadow_word_write(pointers[k], values[k]);
		for (int n = 1; n <= 22; n++)
		begin
			next_cycle();
			@(negedge clk);
			if (n >= 2 && n <= 16 && issue_ready)
				stop_run("issue_ready was high while the scatter walked its lanes");
			if (n >= 17 && !issue_ready)
				stop_run("issue_ready stayed low after the scatter finished");
			if (result_valid)
				stop_run("The scatter produced a load result");
		end
		mask = $urandom;
		expected.thread = 3;
		expected.mask = mask;
		for (int k = 0; k < vector_lanes; k++)
			expected.data[k] = mask[k] ? shadow_word(pointers[k]) : '0;
		issue_op(make_issue(make_inst(1'b1, MEM_SCGATH_M, 0), 3, '0, mask, '0, pointers));
		wait_result("masked gather", 19);
		compare_result("masked gather", expected, result);
	endtask

	task automatic io_test();
		scalar_t value;
		vector_t data;
		int pulses;
		value = $urandom;
		data = '0;
		data[0] = value;
		pulses = 0;
		issue_op(make_issue(make_inst(1'b0, MEM_B, 0), 0, 32'hffff_0010, '0, data, '0));
		for (int n = 1; n <= 8; n++)
		begin
			next_cycle();
			@(negedge clk);
			if (result_valid)
				stop_run("The I/O store produced a load result");
			if (io_write_en)
			begin
				pulses++;
				compare_valid("I/O strobe timing", 3, n);
				compare_io_byte("I/O store byte", value[7:0], io_write_data);
			end
		end
		if (pulses != 1)
			stop_run($sformatf("I/O store gave %0d io_write_en pulses instead of one", pulses));
		// Same low address bits in the array must be untouched
		scalar_load("array word after I/O store", MEM_L, 32'h0000_0010, 0);
		issue_op(make_issue(make_inst(1'b1, MEM_L, 0), 0, 32'hffff_0010, '0, '0, '0));
		expect_quiet(8);
	endtask

	task automatic rollback_test();
		scalar_t addr;
		addr = $urandom & 32'h0000_03fc;
		store_with_rollback(addr, ~shadow_word(addr), 1, 1);
		scalar_load("word load after rolled-back store", MEM_L, addr, 1);
		store_with_rollback(addr, ~shadow_word(addr), 1, 2);
		scalar_load("word load after other-thread rollback", MEM_L, addr, 1);
	endtask

	initial
	begin
		issue_valid = 1'b0;
		issue = '0;
		rollback_en = 1'b0;
		rollback_thread = '0;
		void'($urandom(32'hb006876f));
		wait (reset === 1'b1);
		wait (reset === 1'b0);
		@(negedge clk);
		if (!issue_ready || result_valid || io_write_en)
			stop_run("DUT outputs were not idle after reset");

		init_array_test();
		scalar_store_load_test();
		extend_test();
		block_mask_test();
		scatter_gather_test();
		io_test();
		rollback_test();

		$display("Test passed");
		$finish;
	end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen(
	output logic clk,
	output logic reset
);

	localparam int half_period = 50;
	localparam int reset_cycles = 10;

	initial
	begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
	end

endmodule
